// ==== common/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// integer register width, also the pc width
`define RV_XLEN 64

// architectural integer registers, x0 reads as zero
`define RV_NREGS 32

// system bus data width
`define RV_BUS_W 64

// bus tag width, one tag per fetch transaction
`define RV_TAG_W 13

`endif

// ==== common/rv_pkg.sv ====
`default_nettype none

`include "rv_cfg.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] xword_t;
  typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

  // major opcodes handled by the core
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct3 codes, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL     = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 codes for register-register ops
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // one fetched word, read through whichever format the opcode calls for
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    u_fmt_t u;
  } instr_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

endpackage

`default_nettype wire

// ==== common/exec_if.sv ====
`default_nettype none

// one decoded instruction travelling from decode to execute
interface exec_if
  import rv_pkg::*;
();

  logic     valid;
  xword_t   pc;
  reg_idx_t rd;
  alu_op_e  alu_op;
  // operand b already holds the immediate for I and U formats
  xword_t   opnd_a;
  xword_t   opnd_b;

  modport src (
    output valid,
    output pc,
    output rd,
    output alu_op,
    output opnd_a,
    output opnd_b
  );

  modport dst (
    input valid,
    input pc,
    input rd,
    input alu_op,
    input opnd_a,
    input opnd_b
  );

endinterface

`default_nettype wire

// ==== hw/fetch_unit.sv ====
`default_nettype none

`include "rv_cfg.svh"

module fetch_unit
  import rv_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  xword_t               entry,
  output logic                 bus_reqcyc,
  output logic [`RV_BUS_W-1:0] bus_req,
  output logic [`RV_TAG_W-1:0] bus_reqtag,
  input  logic                 bus_reqack,
  input  logic                 bus_respcyc,
  input  logic [`RV_BUS_W-1:0] bus_resp,
  input  logic [`RV_TAG_W-1:0] bus_resptag,
  output logic                 bus_respack,
  output logic                 f_valid,
  output xword_t               f_pc,
  output instr_t               f_instr
);

  typedef enum logic [1:0] {
    S_REQ,
    S_WAIT,
    S_NEXT
  } fetch_state_e;

  fetch_state_e         state;
  xword_t               pc;
  logic [`RV_TAG_W-1:0] tag;
  logic                 resp_hit;

  // only a response carrying the outstanding tag is ours, stale ones fall through
  assign resp_hit = (state == S_WAIT) && bus_respcyc && (bus_resptag == tag);

  // pc and tag only move on acceptance, so the request stays stable until acked
  assign bus_reqcyc = (state == S_REQ);
  assign bus_req    = pc;
  assign bus_reqtag = tag;

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= S_NEXT;
      pc          <= entry;
      tag         <= '0;
      bus_respack <= 1'b0;
      f_valid     <= 1'b0;
    end else begin
      bus_respack <= resp_hit;
      f_valid     <= resp_hit;
      case (state)
        S_NEXT: begin
          state <= S_REQ;
        end
        S_REQ: begin
          if (bus_reqack) begin
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (resp_hit) begin
            // straight-line code, the next word is always pc+4
            state <= S_NEXT;
            pc    <= pc + xword_t'(4);
            tag   <= tag + `RV_TAG_W'(1);
          end
        end
        default: begin
          state <= S_NEXT;
        end
      endcase
    end
  end

  // instruction payload for decode
  always_ff @(posedge clk) begin
    if (resp_hit) begin
      f_pc    <= pc;
      f_instr <= bus_resp[$bits(instr_t)-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`default_nettype none

`include "rv_cfg.svh"

module decode_stage
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  xword_t   stackptr,
  input  logic     f_valid,
  input  xword_t   f_pc,
  input  instr_t   f_instr,
  input  logic     ex_valid,
  input  reg_idx_t ex_rd,
  input  xword_t   ex_result,
  input  logic     wb_en,
  input  reg_idx_t wb_rd,
  input  xword_t   wb_data,
  exec_if.src      exq
);

  xword_t  regs [`RV_NREGS];
  logic    dec_ok;
  alu_op_e dec_op;
  logic    use_imm;
  xword_t  imm_val;
  xword_t  rs1_val;
  xword_t  rs2_val;

  // youngest producer wins: execute result, then the writeback port, then the file
  function automatic xword_t read_opnd(input reg_idx_t idx);
    xword_t val;
    if (idx == '0) begin
      val = '0;
    end else if (ex_valid && (ex_rd == idx)) begin
      val = ex_result;
    end else if (wb_en && (wb_rd == idx)) begin
      val = wb_data;
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  always_comb begin
    rs1_val = read_opnd(f_instr.r.rs1);
    rs2_val = read_opnd(f_instr.r.rs2);
  end

  always_comb begin
    dec_ok  = 1'b1;
    dec_op  = ALU_ADD;
    use_imm = 1'b0;
    imm_val = {{(`RV_XLEN-12){f_instr.i.imm12[11]}}, f_instr.i.imm12};
    case (f_instr.r.opcode)
      OPC_OP: begin
        case (f_instr.r.funct3)
          F3_ADD_SUB: dec_op = (f_instr.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
          F3_SLL:     dec_op = ALU_SLL;
          F3_SLT:     dec_op = ALU_SLT;
          F3_XOR:     dec_op = ALU_XOR;
          F3_SRL:     dec_op = ALU_SRL;
          F3_OR:      dec_op = ALU_OR;
          F3_AND:     dec_op = ALU_AND;
          default:    dec_ok = 1'b0;
        endcase
        // funct7 is zero except for SUB; SRA and friends are not supported
        if ((f_instr.r.funct7 != F7_BASE) &&
            !((f_instr.r.funct7 == F7_SUB) && (f_instr.r.funct3 == F3_ADD_SUB))) begin
          dec_ok = 1'b0;
        end
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        case (f_instr.i.funct3)
          F3_ADD_SUB: dec_op = ALU_ADD;
          F3_SLT:     dec_op = ALU_SLT;
          F3_XOR:     dec_op = ALU_XOR;
          F3_OR:      dec_op = ALU_OR;
          F3_AND:     dec_op = ALU_AND;
          default:    dec_ok = 1'b0;
        endcase
      end
      OPC_LUI: begin
        use_imm = 1'b1;
        dec_op  = ALU_PASS_B;
        imm_val = {{(`RV_XLEN-32){f_instr.u.imm20[19]}}, f_instr.u.imm20, 12'b0};
      end
      default: begin
        dec_ok = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      exq.valid <= 1'b0;
    end else begin
      exq.valid <= f_valid && dec_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (f_valid) begin
      exq.pc     <= f_pc;
      exq.rd     <= f_instr.r.rd;
      exq.alu_op <= dec_op;
      exq.opnd_a <= rs1_val;
      exq.opnd_b <= use_imm ? imm_val : rs2_val;
    end
  end

  // register file, x2 starts out as the stack pointer
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
      regs[2] <= stackptr;
    end else if (wb_en && (wb_rd != '0)) begin
      regs[wb_rd] <= wb_data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`default_nettype none

`include "rv_cfg.svh"

module execute_stage
  import rv_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  exec_if.dst      exq,
  output logic     ex_valid,
  output reg_idx_t ex_rd,
  output xword_t   ex_result,
  output logic     wb_en,
  output reg_idx_t wb_rd,
  output xword_t   wb_data
);

  logic [$clog2(`RV_XLEN)-1:0] shamt;
  logic                        lt;

  assign shamt = exq.opnd_b[$clog2(`RV_XLEN)-1:0];
  assign lt    = $signed(exq.opnd_a) < $signed(exq.opnd_b);

  always_comb begin
    case (exq.alu_op)
      ALU_ADD:    ex_result = exq.opnd_a + exq.opnd_b;
      ALU_SUB:    ex_result = exq.opnd_a - exq.opnd_b;
      ALU_AND:    ex_result = exq.opnd_a & exq.opnd_b;
      ALU_OR:     ex_result = exq.opnd_a | exq.opnd_b;
      ALU_XOR:    ex_result = exq.opnd_a ^ exq.opnd_b;
      ALU_SLL:    ex_result = exq.opnd_a << shamt;
      ALU_SRL:    ex_result = exq.opnd_a >> shamt;
      ALU_SLT:    ex_result = {{(`RV_XLEN-1){1'b0}}, lt};
      ALU_PASS_B: ex_result = exq.opnd_b;
      default:    ex_result = '0;
    endcase
  end

  // the live result doubles as the first bypass source for decode
  assign ex_valid = exq.valid;
  assign ex_rd    = exq.rd;

  // writeback register, also the retire trace
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_en <= 1'b0;
    end else begin
      wb_en <= exq.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (exq.valid) begin
      wb_rd   <= exq.rd;
      wb_data <= ex_result;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rv_core_top.sv ====
`default_nettype none

`include "rv_cfg.svh"

module rv_core_top
  import rv_pkg::*;
(
  input  logic                           clk,
  input  logic                           reset,
  input  logic [`RV_XLEN-1:0]            entry,
  input  logic [`RV_XLEN-1:0]            stackptr,
  output logic                           bus_reqcyc,
  output logic                           bus_respack,
  output logic [`RV_BUS_W-1:0]           bus_req,
  output logic [`RV_TAG_W-1:0]           bus_reqtag,
  input  logic                           bus_reqack,
  input  logic                           bus_respcyc,
  input  logic [`RV_BUS_W-1:0]           bus_resp,
  input  logic [`RV_TAG_W-1:0]           bus_resptag,
  output logic                           retire_valid,
  output logic [$clog2(`RV_NREGS)-1:0]   retire_rd,
  output logic [`RV_XLEN-1:0]            retire_data
);

  // fetch to decode
  logic     f_valid;
  xword_t   f_pc;
  instr_t   f_instr;

  // execute result, fed back for bypass
  logic     ex_valid;
  reg_idx_t ex_rd;
  xword_t   ex_result;

  // writeback port
  logic     wb_en;
  reg_idx_t wb_rd;
  xword_t   wb_data;

  exec_if exq ();

  fetch_unit u_fetch (
    .clk         (clk),
    .reset       (reset),
    .entry       (entry),
    .bus_reqcyc  (bus_reqcyc),
    .bus_req     (bus_req),
    .bus_reqtag  (bus_reqtag),
    .bus_reqack  (bus_reqack),
    .bus_respcyc (bus_respcyc),
    .bus_resp    (bus_resp),
    .bus_resptag (bus_resptag),
    .bus_respack (bus_respack),
    .f_valid     (f_valid),
    .f_pc        (f_pc),
    .f_instr     (f_instr)
  );

  decode_stage u_decode (
    .clk       (clk),
    .reset     (reset),
    .stackptr  (stackptr),
    .f_valid   (f_valid),
    .f_pc      (f_pc),
    .f_instr   (f_instr),
    .ex_valid  (ex_valid),
    .ex_rd     (ex_rd),
    .ex_result (ex_result),
    .wb_en     (wb_en),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .exq       (exq.src)
  );

  execute_stage u_execute (
    .clk       (clk),
    .reset     (reset),
    .exq       (exq.dst),
    .ex_valid  (ex_valid),
    .ex_rd     (ex_rd),
    .ex_result (ex_result),
    .wb_en     (wb_en),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

  // every writeback is one retired instruction
  assign retire_valid = wb_en;
  assign retire_rd    = wb_rd;
  assign retire_data  = wb_data;

endmodule

`default_nettype wire

// ==== verif/core_asserts.sv ====
`default_nettype none

`include "rv_cfg.svh"

module core_asserts (
  input logic                 clk,
  input logic                 reset,
  input logic                 bus_reqcyc,
  input logic                 bus_reqack,
  input logic [`RV_BUS_W-1:0] bus_req,
  input logic [`RV_TAG_W-1:0] bus_reqtag,
  input logic                 bus_respack,
  input logic                 retire_valid
);

  // an unacked request has to stay put until the memory takes it
  req_stable: assert property (@(posedge clk) disable iff (reset)
    (bus_reqcyc && !bus_reqack) |=>
      (bus_reqcyc && $stable(bus_req) && $stable(bus_reqtag)))
    else $error("bus request dropped or changed before reqack");

  respack_pulse: assert property (@(posedge clk) disable iff (reset)
    bus_respack |=> !bus_respack)
    else $error("bus_respack held longer than one cycle");

  // at most one retire per fetch, so never two in a row
  retire_gap: assert property (@(posedge clk) disable iff (reset)
    retire_valid |=> !retire_valid)
    else $error("retire_valid high on two consecutive cycles");

endmodule

bind rv_core_top core_asserts u_asserts (
  .clk          (clk),
  .reset        (reset),
  .bus_reqcyc   (bus_reqcyc),
  .bus_reqack   (bus_reqack),
  .bus_req      (bus_req),
  .bus_reqtag   (bus_reqtag),
  .bus_respack  (bus_respack),
  .retire_valid (retire_valid)
);

`default_nettype wire

// ==== verif/core_tb.sv ====
`default_nettype none

`include "rv_cfg.svh"

module core_tb
  import rv_pkg::*;
();

  logic                 clk;
  logic                 reset;
  xword_t               entry;
  xword_t               stackptr;
  logic                 bus_reqcyc;
  logic                 bus_respack;
  logic [`RV_BUS_W-1:0] bus_req;
  logic [`RV_TAG_W-1:0] bus_reqtag;
  logic                 bus_reqack;
  logic                 bus_respcyc;
  logic [`RV_BUS_W-1:0] bus_resp;
  logic [`RV_TAG_W-1:0] bus_resptag;
  logic                 retire_valid;
  reg_idx_t             retire_rd;
  xword_t               retire_data;

  // instruction memory, word index from address bits 9:2
  logic [31:0] imem [256];
  logic [31:0] prog_q [$];
  // reference model state
  xword_t      mreg [`RV_NREGS];
  xword_t      model_pc;
  logic [`RV_TAG_W-1:0] model_tag;
  reg_idx_t    exp_rd_q [$];
  xword_t      exp_data_q [$];
  int          errors;
  int          test_errs_start;
  int          tests_run;
  int          tests_failed;

  rv_core_top UUT (
    .clk          (clk),
    .reset        (reset),
    .entry        (entry),
    .stackptr     (stackptr),
    .bus_reqcyc   (bus_reqcyc),
    .bus_respack  (bus_respack),
    .bus_req      (bus_req),
    .bus_reqtag   (bus_reqtag),
    .bus_reqack   (bus_reqack),
    .bus_respcyc  (bus_respcyc),
    .bus_resp     (bus_resp),
    .bus_resptag  (bus_resptag),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] r_op(input int f7, input int f3, input int rd,
                                       input int rs1, input int rs2);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] i_op(input int f3, input int rd, input int rs1,
                                       input int imm);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'b0010011};
  endfunction

  function automatic logic [31:0] lui(input int rd, input int imm20);
    return {20'(imm20), 5'(rd), 7'b0110111};
  endfunction

  // architectural result of one RV64I word, straight from the ISA rules
  function automatic void model_step(input logic [31:0] w, output bit retires,
                                     output reg_idx_t rd, output xword_t val);
    xword_t     a;
    xword_t     b;
    xword_t     imm;
    logic [2:0] f3;
    logic [6:0] f7;
    retires = 1'b1;
    rd      = w[11:7];
    f3      = w[14:12];
    f7      = w[31:25];
    a       = mreg[w[19:15]];
    b       = mreg[w[24:20]];
    imm     = {{52{w[31]}}, w[31:20]};
    val     = '0;
    case (w[6:0])
      7'b0110011: begin
        if ((f7 == 7'h20) && (f3 == 3'd0)) begin
          val = a - b;
        end else if (f7 != 7'h00) begin
          retires = 1'b0;
        end else begin
          case (f3)
            3'd0: val = a + b;
            3'd1: val = a << b[5:0];
            3'd2: val = {63'd0, $signed(a) < $signed(b)};
            3'd4: val = a ^ b;
            3'd5: val = a >> b[5:0];
            3'd6: val = a | b;
            3'd7: val = a & b;
            default: retires = 1'b0;
          endcase
        end
      end
      7'b0010011: begin
        case (f3)
          3'd0: val = a + imm;
          3'd2: val = {63'd0, $signed(a) < $signed(imm)};
          3'd4: val = a ^ imm;
          3'd6: val = a | imm;
          3'd7: val = a & imm;
          default: retires = 1'b0;
        endcase
      end
      7'b0110111: val = {{32{w[31]}}, w[31:12], 12'h000};
      default: retires = 1'b0;
    endcase
    if (retires && (rd != '0)) begin
      mreg[rd] = val;
    end
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input xword_t got, input xword_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_tag(input string name, input logic [`RV_TAG_W-1:0] got,
                           input logic [`RV_TAG_W-1:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_retire(input reg_idx_t got_rd, input xword_t got_data,
                              input reg_idx_t exp_rd, input xword_t exp_data);
    if (got_rd !== exp_rd) begin
      $display("error at %0t: retire_rd is %0d, expected %0d", $time, got_rd, exp_rd);
      errors++;
    end
    if (got_data !== exp_data) begin
      $display("error at %0t: retire_data is %h, expected %h", $time, got_data, exp_data);
      errors++;
    end
  endtask

  // one falling edge, and whatever retired on the rising edge before it
  task automatic step();
    @(negedge clk);
    if (retire_valid === 1'b1) begin
      if (exp_rd_q.size() == 0) begin
        $display("unexpected retire at %0t: x%0d = %h", $time, retire_rd, retire_data);
        errors++;
      end else begin
        check_retire(retire_rd, retire_data, exp_rd_q.pop_front(), exp_data_q.pop_front());
      end
    end
  endtask

  task automatic apply_reset(input xword_t start_pc, input xword_t sp);
    test_errs_start = errors;
    reset       = 1'b1;
    entry       = start_pc;
    stackptr    = sp;
    bus_reqack  = 1'b0;
    bus_respcyc = 1'b0;
    repeat (10) begin
      step();
      check_bit("bus_reqcyc", bus_reqcyc, 1'b0);
      check_bit("bus_respack", bus_respack, 1'b0);
      check_bit("f_valid", UUT.f_valid, 1'b0);
      check_bit("exq.valid", UUT.exq.valid, 1'b0);
      check_bit("retire_valid", retire_valid, 1'b0);
    end
    reset = 1'b0;
    for (int i = 0; i < `RV_NREGS; i++) begin
      mreg[i] = '0;
    end
    mreg[2]   = sp;
    model_pc  = start_pc;
    model_tag = '0;
    exp_rd_q.delete();
    exp_data_q.delete();
    prog_q.delete();
    // opcode zero everywhere else, so stray fetches never retire
    for (int i = 0; i < 256; i++) begin
      imem[i] = {i[23:0], 8'h00};
    end
  endtask

  task automatic serve_fetch(input int max_ack, input int max_resp, input bit stale);
    int                   n;
    int                   ack_dly;
    int                   resp_dly;
    logic [`RV_TAG_W-1:0] tag;
    logic [31:0]          word;
    bit                   retires;
    reg_idx_t             rd;
    xword_t               val;
    ack_dly  = $urandom_range(max_ack, 0);
    resp_dly = $urandom_range(max_resp, 0);
    n = 0;
    while ((bus_reqcyc !== 1'b1) && (n < 40)) begin
      step();
      n++;
    end
    if (bus_reqcyc !== 1'b1) begin
      $display("timeout at %0t: core never raised bus_reqcyc", $time);
      errors++;
      return;
    end
    check_addr("bus_req", bus_req, model_pc);
    check_tag("bus_reqtag", bus_reqtag, model_tag);
    tag  = bus_reqtag;
    word = imem[bus_req[9:2]];
    repeat (ack_dly) step();
    bus_reqack = 1'b1;
    step();
    bus_reqack = 1'b0;
    if (stale) begin
      // response meant for another transaction
      bus_respcyc = 1'b1;
      bus_resptag = ~tag;
      bus_resp    = {32'($urandom), i_op(0, 31, 0, 1234)};
      repeat (2) begin
        step();
        check_bit("bus_respack", bus_respack, 1'b0);
      end
      bus_respcyc = 1'b0;
      step();
      check_bit("bus_respack", bus_respack, 1'b0);
    end
    repeat (resp_dly) step();
    model_step(word, retires, rd, val);
    if (retires) begin
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(val);
    end
    model_pc    = model_pc + 64'd4;
    model_tag   = model_tag + 1'b1;
    bus_respcyc = 1'b1;
    bus_resptag = tag;
    bus_resp    = {32'($urandom), word};
    n = 0;
    do begin
      step();
      n++;
    end while ((bus_respack !== 1'b1) && (n < 20));
    bus_respcyc = 1'b0;
    if (bus_respack !== 1'b1) begin
      $display("timeout at %0t: core never acknowledged the response", $time);
      errors++;
    end
  endtask

  task automatic run_program(input int max_ack, input int max_resp, input int stale_every);
    int         n;
    logic [7:0] base;
    base = model_pc[9:2];
    foreach (prog_q[k]) begin
      imem[base + 8'(k)] = prog_q[k];
    end
    foreach (prog_q[k]) begin
      serve_fetch(max_ack, max_resp, (stale_every > 0) && ((k % stale_every) == 1));
    end
    n = 0;
    while ((exp_rd_q.size() != 0) && (n < 20)) begin
      step();
      n++;
    end
    if (exp_rd_q.size() != 0) begin
      $display("timeout at %0t: %0d instructions never retired", $time, exp_rd_q.size());
      errors++;
    end
    // core now sits on an unserved request, nothing more may retire
    repeat (4) step();
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != test_errs_start) begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - test_errs_start);
    end else begin
      $display("%s: passed", name);
    end
  endtask

  task automatic test_reset_fetch();
    apply_reset(64'h0000_0000_8000_0000, 64'h0000_0000_0010_0000);
    repeat (4) prog_q.push_back(32'h0000_0000);
    run_program(5, 5, 0);
    finish_test("reset and first fetch");
  endtask

  task automatic test_rtype();
    apply_reset(64'h0000_0000_0000_1000, 64'h0000_0000_0008_0000);
    prog_q.push_back(i_op(0, 1, 0, -100));
    prog_q.push_back(lui(3, 32'h12345));
    prog_q.push_back(i_op(0, 3, 3, 32'h678));
    prog_q.push_back(i_op(0, 4, 0, 7));
    prog_q.push_back(r_op(0, 0, 5, 1, 3));
    prog_q.push_back(r_op(32, 0, 6, 1, 3));
    prog_q.push_back(r_op(0, 7, 7, 3, 1));
    prog_q.push_back(r_op(0, 6, 8, 1, 3));
    prog_q.push_back(r_op(0, 4, 9, 1, 3));
    prog_q.push_back(r_op(0, 1, 10, 3, 4));
    prog_q.push_back(r_op(0, 5, 11, 1, 4));
    prog_q.push_back(r_op(0, 2, 12, 1, 3));
    prog_q.push_back(r_op(0, 2, 13, 3, 1));
    run_program(5, 5, 0);
    finish_test("r-type operations");
  endtask

  task automatic test_imm();
    apply_reset(64'h0000_0000_0000_2040, 64'h0000_7fff_fff0_1238);
    // x2 read before any write must give the stack pointer
    prog_q.push_back(i_op(0, 5, 2, 0));
    prog_q.push_back(i_op(7, 6, 2, -16));
    prog_q.push_back(i_op(0, 1, 0, -1));
    prog_q.push_back(i_op(6, 7, 0, -2048));
    prog_q.push_back(i_op(4, 8, 1, 32'h555));
    prog_q.push_back(i_op(2, 9, 1, 0));
    prog_q.push_back(i_op(2, 10, 5, -1));
    prog_q.push_back(lui(11, 32'h80000));
    prog_q.push_back(lui(12, 32'hfffff));
    prog_q.push_back(lui(13, 32'h7ffff));
    run_program(5, 5, 0);
    finish_test("immediates and lui");
  endtask

  task automatic test_chain();
    apply_reset(64'h0000_0000_0000_0300, 64'h0000_0000_0000_8000);
    prog_q.push_back(i_op(0, 1, 0, 1));
    repeat (6) prog_q.push_back(r_op(0, 0, 1, 1, 1));
    prog_q.push_back(r_op(0, 1, 2, 1, 1));
    prog_q.push_back(r_op(32, 0, 3, 2, 1));
    prog_q.push_back(r_op(0, 4, 3, 3, 2));
    prog_q.push_back(i_op(0, 3, 3, -5));
    prog_q.push_back(r_op(0, 6, 4, 3, 1));
    prog_q.push_back(r_op(0, 2, 5, 4, 3));
    run_program(0, 0, 0);
    finish_test("dependency chains");
  endtask

  task automatic test_x0_unknown();
    apply_reset(64'h0000_0000_0000_0800, 64'h0000_0000_0000_4000);
    prog_q.push_back(i_op(0, 0, 0, 123));
    prog_q.push_back(r_op(0, 0, 1, 0, 0));
    prog_q.push_back(32'h0000_007f);
    prog_q.push_back(i_op(0, 2, 0, 5));
    // slli is outside the supported subset
    prog_q.push_back(i_op(1, 6, 2, 3));
    prog_q.push_back(lui(0, 32'habcde));
    prog_q.push_back(i_op(0, 3, 0, 1));
    prog_q.push_back(r_op(0, 6, 4, 0, 2));
    run_program(3, 3, 0);
    finish_test("register 0 and unknown opcodes");
  endtask

  task automatic test_stall_stale();
    apply_reset(64'h0000_0000_0000_0f00, 64'h0000_0000_0002_0000);
    prog_q.push_back(i_op(0, 1, 0, 42));
    prog_q.push_back(lui(2, 1));
    prog_q.push_back(r_op(0, 0, 3, 1, 2));
    prog_q.push_back(r_op(32, 0, 4, 3, 1));
    prog_q.push_back(i_op(4, 5, 4, -1));
    prog_q.push_back(r_op(0, 5, 6, 5, 1));
    prog_q.push_back(r_op(0, 2, 7, 5, 4));
    prog_q.push_back(r_op(0, 7, 8, 6, 3));
    run_program(12, 5, 2);
    finish_test("bus stalls and stale tags");
  endtask

  initial begin
    void'($urandom(32'hac1d_3467));
    clk             = 1'b0;
    reset           = 1'b1;
    entry           = '0;
    stackptr        = '0;
    bus_reqack      = 1'b0;
    bus_respcyc     = 1'b0;
    bus_resp        = '0;
    bus_resptag     = '0;
    errors          = 0;
    test_errs_start = 0;
    tests_run       = 0;
    tests_failed    = 0;
    test_reset_fetch();
    test_rtype();
    test_imm();
    test_chain();
    test_x0_unknown();
    test_stall_stale();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+common
common/rv_pkg.sv
common/exec_if.sv
hw/fetch_unit.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/rv_core_top.sv
verif/core_asserts.sv
verif/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the core testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module core_tb -f flist.f -o core_sim \
  > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/core_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

grep -qx "Test OK" sim.log
grep_status=$?
if [ $grep_status -ne 0 ]; then
  echo "pass line missing from sim.log"
  exit 1
fi

exit 0
